//--- prog.hex
// Hex instruction words, opcode[31:28] rd[27:24] rs1[23:20] then rs2 or imm
// Lines starting with @ set the word address
@00
A0000020  // jal  r0, +32
@10
5AA003E8  // addi r10, r10, 1000
B0000000  // mret
@20
51000007  // addi r1, r0, 7
52000005  // addi r2, r0, 5
03120000  // add  r3, r1, r2
54000003  // addi r4, r0, 3
43340000  // xor  r3, r3, r4
550000FF  // addi r5, r0, 255
23350000  // and  r3, r3, r5
56000001  // addi r6, r0, 1
13360000  // sub  r3, r3, r6
83000200  // sw   r3, 0x200(r0)
77000200  // lw   r7, 0x200(r0)
57700064  // addi r7, r7, 100
59000004  // addi r9, r0, 4
58800001  // addi r8, r8, 1
99800002  // beq  r8, r9, +2
A00FFFFE  // jal  r0, -2
C0000000  // wfi
0B370000  // add  r11, r3, r7
0BB80000  // add  r11, r11, r8
0BBA0000  // add  r11, r11, r10
6C010000  // lui  r12, 0x10000
8BC00000  // sw   r11, 0(r12)
A0000000  // jal  r0, 0

//--- flist.f
hw/mini_mcu_pkg.sv
hw/register_file.sv
hw/mini_core.sv
hw/cpu_subsystem.sv
hw/obi_ram.sv
hw/data_bus_demux.sv
hw/soc_ctrl.sv
hw/mini_mcu.sv
testbench/tb_mini_mcu.sv

//--- Makefile
# Verilator build and run of the mini MCU testbench

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_mini_mcu.sv
// Mini MCU testbench with clock, reset and interrupt stimulus
// Checks boot, WFI sleep, interrupt entry and masking, and the exit value
module tb_mini_mcu;
    import mini_mcu_pkg::*;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [NUM_IRQ-1:0] irq;
    logic               irq_ack;
    logic [3:0]         irq_id;
    logic               core_sleep;
    logic               exit_valid;
    logic [31:0]        exit_value;
    logic [3:0]         pending_id;

    logic [31:0] rng_state;
    logic [3:0]  line_a;
    logic [3:0]  line_b;
    logic        aborted;
    int unsigned err_count;
    int unsigned prop_err_count;
    int unsigned test_count;
    int unsigned test_fail_count;
    int unsigned test_err_start;
    int unsigned ack_count;
    int unsigned lines_raised;

    always #5 clk = ~clk;

    mini_mcu i_mini_mcu (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .irq_i        (irq),
        .irq_ack_o    (irq_ack),
        .irq_id_o     (irq_id),
        .core_sleep_o (core_sleep),
        .exit_valid_o (exit_valid),
        .exit_value_o (exit_value)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Lowest set line has priority
    function automatic logic [3:0] lowest_line(input logic [NUM_IRQ-1:0] lines);
        logic [3:0] id;
        logic       found;
        id    = 4'd0;
        found = 1'b0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (lines[i] && !found) begin
                id    = i[3:0];
                found = 1'b1;
            end
        end
        return id;
    endfunction

    function automatic logic [NUM_IRQ-1:0] one_hot(input logic [3:0] line);
        logic [NUM_IRQ-1:0] vec;
        vec       = '0;
        vec[line] = 1'b1;
        return vec;
    endfunction

    // Model of the test program, one handler run per acknowledged interrupt
    function automatic logic [31:0] expected_exit(input int unsigned handlers);
        logic [31:0] arith;
        logic [31:0] loaded;
        logic [31:0] loop_count;
        arith      = (((32'd7 + 32'd5) ^ 32'd3) & 32'd255) - 32'd1;
        loaded     = arith + 32'd100;
        loop_count = 32'd4;
        return arith + loaded + loop_count + handlers * 32'd1000;
    endfunction

    assign pending_id = lowest_line(irq);

    task automatic prop_error(input string msg);
        $display("FAILED t=%0t: %s", $time, msg);
        prop_err_count++;
    endtask

    task automatic value_error(input string msg);
        $display("FAILED t=%0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic timeout_error(input string what);
        $display("Timed out at t=%0t waiting for %s", $time, what);
        err_count++;
        aborted = 1'b1;
    endtask

    ack_id_check: assert property (@(posedge clk) disable iff (!rst_n)
        irq_ack |-> (irq != '0) && (irq_id == pending_id))
        else prop_error("irq_id_o does not name the lowest pending line");

    // Entry clears the enable, so ack lasts one cycle
    ack_pulse_check: assert property (@(posedge clk) disable iff (!rst_n)
        irq_ack |=> !irq_ack)
        else prop_error("irq_ack_o high for more than one cycle");

    sleep_wake_check: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(core_sleep) |-> (irq != '0))
        else prop_error("core_sleep_o fell with no interrupt pending");

    exit_sticky_check: assert property (@(posedge clk) disable iff (!rst_n)
        exit_valid |=> exit_valid && $stable(exit_value))
        else prop_error("exit_valid_o or exit_value_o changed after exit");

    always @(posedge clk) begin
        if (!rst_n) begin
            ack_count <= 0;
        end else if (irq_ack) begin
            ack_count <= ack_count + 1;
        end
    end

    task automatic start_test();
        test_err_start = err_count + prop_err_count;
        test_count++;
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        errs = err_count + prop_err_count - test_err_start;
        if (errs == 0) begin
            $display("test %s done, no errors", name);
        end else begin
            $display("test %s done, %0d errors", name, errs);
            test_fail_count++;
        end
    endtask

    // Nothing acknowledged or exited before the program sleeps
    task automatic boot_quiet_test(input int unsigned timeout);
        int unsigned cycles;
        start_test();
        cycles = 0;
        @(negedge clk);
        while (!core_sleep && cycles < timeout) begin
            assert (!irq_ack && !exit_valid)
                else value_error("irq_ack_o or exit_valid_o high before WFI");
            @(negedge clk);
            cycles++;
        end
        if (!core_sleep) begin
            timeout_error("core_sleep_o to rise at WFI");
        end
        finish_test("boot_quiet");
    endtask

    task automatic sleep_hold_test();
        int unsigned hold;
        start_test();
        rng_state = lcg_next(rng_state);
        hold      = 5 + int'(rng_state[19:16]);
        for (int unsigned i = 0; i < hold; i++) begin
            @(negedge clk);
            assert (core_sleep && !irq_ack)
                else value_error("core_sleep_o dropped while irq_i is zero");
        end
        finish_test("sleep_hold");
    endtask

    task automatic wake_ack_test(input int unsigned timeout);
        int unsigned cycles;
        logic        seen;
        start_test();
        rng_state = lcg_next(rng_state);
        line_a    = rng_state[19:16];
        irq       = one_hot(line_a);
        lines_raised++;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < timeout) begin
            @(negedge clk);
            cycles++;
            assert (!core_sleep) else value_error("core_sleep_o high with a line pending");
            if (irq_ack) begin
                seen = 1'b1;
                assert (irq_id == line_a) else value_error("wrong irq_id_o on wake-up");
            end
        end
        if (!seen) begin
            timeout_error("irq_ack_o after wake-up");
        end else begin
            // Line held through the entry edge
            @(negedge clk);
            assert (!irq_ack) else value_error("irq_ack_o pulsed twice for one line");
        end
        finish_test("wake_ack");
    endtask

    // Second line raised inside the handler, enable still clear
    task automatic masked_irq_test(input int unsigned timeout);
        int unsigned cycles;
        logic        seen;
        start_test();
        rng_state = lcg_next(rng_state);
        line_b    = line_a + 4'd1 + (rng_state[19:16] % 4'd15);
        irq       = one_hot(line_b);
        lines_raised++;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < timeout) begin
            @(negedge clk);
            cycles++;
            if (irq_ack) begin
                seen = 1'b1;
                assert (irq_id == line_b) else value_error("wrong irq_id_o after MRET");
            end
        end
        if (!seen) begin
            timeout_error("irq_ack_o after MRET");
        end else begin
            // Handler is two instructions of fetch, wait and execute
            assert (cycles >= 2 * 3) else value_error("second line acknowledged before MRET");
            @(negedge clk);
            irq = '0;
        end
        finish_test("masked_irq");
    endtask

    task automatic exit_value_test(input int unsigned timeout);
        int unsigned cycles;
        logic [31:0] expected;
        start_test();
        cycles = 0;
        while (!exit_valid && cycles < timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!exit_valid) begin
            timeout_error("exit_valid_o");
        end else begin
            expected = expected_exit(lines_raised);
            assert (exit_value == expected)
                else value_error($sformatf("exit_value_o is %0d, expected %0d",
                                           exit_value, expected));
            assert (ack_count == lines_raised)
                else value_error($sformatf("%0d acks seen, expected %0d",
                                           ack_count, lines_raised));
            // Exit flag and value must hold while the core spins
            for (int unsigned i = 0; i < 4; i++) begin
                @(negedge clk);
            end
        end
        finish_test("exit_value");
    endtask

    initial begin
        rng_state       = 32'hae35_3f8a;
        aborted         = 1'b0;
        err_count       = 0;
        prop_err_count  = 0;
        test_count      = 0;
        test_fail_count = 0;
        lines_raised    = 0;
        line_a          = 4'd0;
        line_b          = 4'd0;
        rst_n           = 1'b0;
        irq             = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        boot_quiet_test(400);
        if (!aborted) begin
            sleep_hold_test();
        end
        if (!aborted) begin
            wake_ack_test(20);
        end
        if (!aborted) begin
            masked_irq_test(60);
        end
        if (!aborted) begin
            exit_value_test(200);
        end

        $display("Tests run: %0d, with errors: %0d, total errors: %0d",
                 test_count, test_fail_count, err_count + prop_err_count);
        if (err_count + prop_err_count == 0 && !aborted) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hw/mini_mcu.sv
// Mini MCU top: CPU subsystem, dual-port RAM, data demux, control block
module mini_mcu (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [mini_mcu_pkg::NUM_IRQ-1:0]    irq_i,
    output logic                                irq_ack_o,
    output logic [3:0]                          irq_id_o,
    output logic                                core_sleep_o,
    output logic                                exit_valid_o,
    output logic [31:0]                         exit_value_o
);
    import mini_mcu_pkg::*;

    obi_req_t  instr_req;
    obi_resp_t instr_resp;
    obi_req_t  data_req;
    obi_resp_t data_resp;
    obi_req_t  ram_b_req;
    obi_resp_t ram_b_resp;
    obi_req_t  ctrl_req;
    obi_resp_t ctrl_resp;

    cpu_subsystem i_cpu_subsystem (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .core_instr_req_o  (instr_req),
        .core_instr_resp_i (instr_resp),
        .core_data_req_o   (data_req),
        .core_data_resp_i  (data_resp),
        .irq_i             (irq_i),
        .irq_ack_o         (irq_ack_o),
        .irq_id_o          (irq_id_o),
        .core_sleep_o      (core_sleep_o)
    );

    obi_ram i_obi_ram (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .a_req_i  (instr_req),
        .a_resp_o (instr_resp),
        .b_req_i  (ram_b_req),
        .b_resp_o (ram_b_resp)
    );

    data_bus_demux i_data_bus_demux (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .core_req_i  (data_req),
        .core_resp_o (data_resp),
        .ram_req_o   (ram_b_req),
        .ram_resp_i  (ram_b_resp),
        .ctrl_req_o  (ctrl_req),
        .ctrl_resp_i (ctrl_resp)
    );

    soc_ctrl i_soc_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (ctrl_req),
        .resp_o       (ctrl_resp),
        .exit_valid_o (exit_valid_o),
        .exit_value_o (exit_value_o)
    );

endmodule

//--- hw/soc_ctrl.sv
// Control block with a single exit register and sticky exit flag
module soc_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mini_mcu_pkg::obi_req_t  req_i,
    output mini_mcu_pkg::obi_resp_t resp_o,
    output logic                    exit_valid_o,
    output logic [31:0]             exit_value_o
);

    logic        exit_valid_q;
    logic [31:0] exit_value_q;
    logic        rvalid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            exit_valid_q <= 1'b0;
            exit_value_q <= '0;
            rvalid_q     <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
            if (req_i.req && req_i.we) begin
                exit_value_q <= req_i.wdata;
                // Stays set until reset
                exit_valid_q <= 1'b1;
            end
        end
    end

    assign resp_o.gnt    = req_i.req;
    assign resp_o.rvalid = rvalid_q;
    assign resp_o.rdata  = exit_value_q;

    assign exit_valid_o = exit_valid_q;
    assign exit_value_o = exit_value_q;

endmodule

//--- hw/data_bus_demux.sv
// Data bus demultiplexer between the RAM and the control block
module data_bus_demux (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mini_mcu_pkg::obi_req_t  core_req_i,
    output mini_mcu_pkg::obi_resp_t core_resp_o,
    output mini_mcu_pkg::obi_req_t  ram_req_o,
    input  mini_mcu_pkg::obi_resp_t ram_resp_i,
    output mini_mcu_pkg::obi_req_t  ctrl_req_o,
    input  mini_mcu_pkg::obi_resp_t ctrl_resp_i
);
    import mini_mcu_pkg::*;

    logic sel_ctrl;
    logic sel_ctrl_q;

    // Top nibble picks the target
    assign sel_ctrl = core_req_i.addr[31:28] == SOC_CTRL_ADDR[31:28];

    always_comb begin
        ram_req_o      = core_req_i;
        ram_req_o.req  = core_req_i.req && !sel_ctrl;
        ctrl_req_o     = core_req_i;
        ctrl_req_o.req = core_req_i.req && sel_ctrl;
    end

    // Target of the granted request, for routing rvalid back
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sel_ctrl_q <= 1'b0;
        end else if (core_req_i.req && core_resp_o.gnt) begin
            sel_ctrl_q <= sel_ctrl;
        end
    end

    always_comb begin
        core_resp_o.gnt    = sel_ctrl ? ctrl_resp_i.gnt : ram_resp_i.gnt;
        core_resp_o.rvalid = sel_ctrl_q ? ctrl_resp_i.rvalid : ram_resp_i.rvalid;
        core_resp_o.rdata  = sel_ctrl_q ? ctrl_resp_i.rdata : ram_resp_i.rdata;
    end

endmodule

//--- hw/obi_ram.sv
// Dual-port program and data RAM, preloaded from a hex image
// Port A is read-only, port B reads and writes with byte enables
module obi_ram (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mini_mcu_pkg::obi_req_t  a_req_i,
    output mini_mcu_pkg::obi_resp_t a_resp_o,
    input  mini_mcu_pkg::obi_req_t  b_req_i,
    output mini_mcu_pkg::obi_resp_t b_resp_o
);
    import mini_mcu_pkg::*;

    logic [31:0]                  mem [RAM_WORDS];
    logic [$clog2(RAM_WORDS)-1:0] a_idx;
    logic [$clog2(RAM_WORDS)-1:0] b_idx;
    logic                         a_rvalid_q;
    logic                         b_rvalid_q;
    logic [31:0]                  a_rdata_q;
    logic [31:0]                  b_rdata_q;

    initial begin
        $readmemh("prog.hex", mem);
    end

    // Word addressed
    assign a_idx = a_req_i.addr[$clog2(RAM_WORDS)+1:2];
    assign b_idx = b_req_i.addr[$clog2(RAM_WORDS)+1:2];

    always_ff @(posedge clk_i) begin
        if (b_req_i.req && b_req_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (b_req_i.be[i]) begin
                    mem[b_idx][8*i +: 8] <= b_req_i.wdata[8*i +: 8];
                end
            end
        end
        a_rdata_q <= mem[a_idx];
        b_rdata_q <= mem[b_idx];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            a_rvalid_q <= 1'b0;
            b_rvalid_q <= 1'b0;
        end else begin
            a_rvalid_q <= a_req_i.req;
            b_rvalid_q <= b_req_i.req;
        end
    end

    // Always ready, so grant follows request
    assign a_resp_o = '{gnt: a_req_i.req, rvalid: a_rvalid_q, rdata: a_rdata_q};
    assign b_resp_o = '{gnt: b_req_i.req, rvalid: b_rvalid_q, rdata: b_rdata_q};

endmodule

//--- hw/cpu_subsystem.sv
// CPU subsystem: core plus register file, read-only instruction port
module cpu_subsystem (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Instruction memory interface
    output mini_mcu_pkg::obi_req_t              core_instr_req_o,
    input  mini_mcu_pkg::obi_resp_t             core_instr_resp_i,
    // Data memory interface
    output mini_mcu_pkg::obi_req_t              core_data_req_o,
    input  mini_mcu_pkg::obi_resp_t             core_data_resp_i,
    // Interrupts and sleep
    input  logic [mini_mcu_pkg::NUM_IRQ-1:0]    irq_i,
    output logic                                irq_ack_o,
    output logic [3:0]                          irq_id_o,
    output logic                                core_sleep_o
);
    import mini_mcu_pkg::*;

    obi_req_t    instr_req;
    logic [3:0]  rf_raddr_a;
    logic [3:0]  rf_raddr_b;
    logic [3:0]  rf_waddr;
    logic [31:0] rf_rdata_a;
    logic [31:0] rf_rdata_b;
    logic [31:0] rf_wdata;
    logic        rf_we;

    // Fetch never writes
    always_comb begin
        core_instr_req_o.req   = instr_req.req;
        core_instr_req_o.addr  = instr_req.addr;
        core_instr_req_o.we    = 1'b0;
        core_instr_req_o.be    = 4'b1111;
        core_instr_req_o.wdata = '0;
    end

    mini_core i_mini_core (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_req_o  (instr_req),
        .instr_resp_i (core_instr_resp_i),
        .data_req_o   (core_data_req_o),
        .data_resp_i  (core_data_resp_i),
        .irq_i        (irq_i),
        .irq_ack_o    (irq_ack_o),
        .irq_id_o     (irq_id_o),
        .core_sleep_o (core_sleep_o),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata),
        .rf_we_o      (rf_we),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b)
    );

    register_file i_register_file (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .we_i      (rf_we),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b)
    );

endmodule

//--- hw/mini_core.sv
// Multi-cycle core: fetch, execute and load/store FSM,
// interrupt entry with MRET return, WFI sleep
module mini_core (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    output mini_mcu_pkg::obi_req_t              instr_req_o,
    input  mini_mcu_pkg::obi_resp_t             instr_resp_i,
    output mini_mcu_pkg::obi_req_t              data_req_o,
    input  mini_mcu_pkg::obi_resp_t             data_resp_i,
    input  logic [mini_mcu_pkg::NUM_IRQ-1:0]    irq_i,
    output logic                                irq_ack_o,
    output logic [3:0]                          irq_id_o,
    output logic                                core_sleep_o,
    output logic [3:0]                          rf_raddr_a_o,
    output logic [3:0]                          rf_raddr_b_o,
    output logic [3:0]                          rf_waddr_o,
    output logic [31:0]                         rf_wdata_o,
    output logic                                rf_we_o,
    input  logic [31:0]                         rf_rdata_a_i,
    input  logic [31:0]                         rf_rdata_b_i
);
    import mini_mcu_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT,
        S_EXEC,
        S_MEM,
        S_MEM_WAIT,
        S_SLEEP
    } state_e;

    state_e      state_q;
    logic [31:0] pc_q;
    logic [31:0] epc_q;
    logic        irq_en_q;
    logic        fetch_held_q;
    instr_u      instr_q;
    obi_req_t    data_req_q;

    opcode_e     opcode;
    logic [31:0] imm_ext;
    logic [31:0] pc_plus4;
    logic [31:0] br_target;
    logic [31:0] pc_next;
    logic [31:0] alu_res;
    logic        writes_rd;
    logic        irq_any;
    logic        irq_take;
    logic [3:0]  irq_id;

    assign opcode    = instr_q.imm_fmt.opcode;
    assign imm_ext   = {{12{instr_q.imm_fmt.imm[19]}}, instr_q.imm_fmt.imm};
    assign pc_plus4  = pc_q + 32'd4;
    // Branch and jump offsets count words
    assign br_target = pc_q + (imm_ext << 2);

    // Lowest set line wins
    always_comb begin
        irq_id = 4'd0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (irq_i[i]) begin
                irq_id = 4'(i);
            end
        end
    end

    assign irq_any  = |irq_i;
    // No entry once a fetch request is already on the bus
    assign irq_take = (state_q == S_FETCH) && !fetch_held_q && irq_en_q && irq_any;

    assign irq_ack_o    = irq_take;
    assign irq_id_o     = irq_id;
    assign core_sleep_o = (state_q == S_SLEEP) && !irq_any;

    always_comb begin
        instr_req_o      = '0;
        instr_req_o.req  = (state_q == S_FETCH) && !irq_take;
        instr_req_o.addr = pc_q;
    end

    assign data_req_o = data_req_q;

    // Register fields read through both instruction views
    assign rf_raddr_a_o = instr_q.reg_fmt.rs1;
    assign rf_raddr_b_o = (opcode == OP_SW || opcode == OP_BEQ) ? instr_q.imm_fmt.rd
                                                                : instr_q.reg_fmt.rs2;
    assign rf_waddr_o   = instr_q.imm_fmt.rd;

    always_comb begin
        alu_res   = '0;
        pc_next   = pc_plus4;
        writes_rd = 1'b1;
        case (opcode)
            OP_ADD:  alu_res = rf_rdata_a_i + rf_rdata_b_i;
            OP_SUB:  alu_res = rf_rdata_a_i - rf_rdata_b_i;
            OP_AND:  alu_res = rf_rdata_a_i & rf_rdata_b_i;
            OP_OR:   alu_res = rf_rdata_a_i | rf_rdata_b_i;
            OP_XOR:  alu_res = rf_rdata_a_i ^ rf_rdata_b_i;
            OP_ADDI: alu_res = rf_rdata_a_i + imm_ext;
            OP_LUI:  alu_res = {instr_q.imm_fmt.imm, 12'h000};
            OP_JAL: begin
                alu_res = pc_plus4;
                pc_next = br_target;
            end
            OP_BEQ: begin
                writes_rd = 1'b0;
                if (rf_rdata_a_i == rf_rdata_b_i) begin
                    pc_next = br_target;
                end
            end
            OP_MRET: begin
                writes_rd = 1'b0;
                pc_next   = epc_q;
            end
            default: writes_rd = 1'b0;
        endcase
    end

    // Load data returns in the rvalid cycle
    assign rf_we_o    = ((state_q == S_EXEC) && writes_rd) ||
                        ((state_q == S_MEM_WAIT) && data_resp_i.rvalid && (opcode == OP_LW));
    assign rf_wdata_o = (state_q == S_MEM_WAIT) ? data_resp_i.rdata : alu_res;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q        <= S_FETCH;
            pc_q           <= BOOT_ADDR;
            epc_q          <= BOOT_ADDR;
            irq_en_q       <= 1'b1;
            fetch_held_q   <= 1'b0;
            data_req_q.req <= 1'b0;
        end else begin
            fetch_held_q <= instr_req_o.req && !instr_resp_i.gnt;
            case (state_q)
                S_FETCH: begin
                    if (irq_take) begin
                        epc_q    <= pc_q;
                        pc_q     <= IRQ_VECTOR;
                        irq_en_q <= 1'b0;
                    end else if (instr_resp_i.gnt) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (instr_resp_i.rvalid) begin
                        instr_q <= instr_resp_i.rdata;
                        state_q <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    pc_q    <= pc_next;
                    state_q <= S_FETCH;
                    case (opcode)
                        OP_LW, OP_SW: begin
                            data_req_q.req   <= 1'b1;
                            data_req_q.we    <= (opcode == OP_SW);
                            data_req_q.be    <= 4'b1111;
                            data_req_q.addr  <= rf_rdata_a_i + imm_ext;
                            data_req_q.wdata <= rf_rdata_b_i;
                            state_q          <= S_MEM;
                        end
                        OP_MRET: irq_en_q <= 1'b1;
                        OP_WFI:  state_q  <= S_SLEEP;
                        default: ;
                    endcase
                end
                S_MEM: begin
                    if (data_resp_i.gnt) begin
                        data_req_q.req <= 1'b0;
                        state_q        <= S_MEM_WAIT;
                    end
                end
                S_MEM_WAIT: begin
                    if (data_resp_i.rvalid) begin
                        state_q <= S_FETCH;
                    end
                end
                S_SLEEP: begin
                    if (irq_any) begin
                        state_q <= S_FETCH;
                    end
                end
                default: state_q <= S_FETCH;
            endcase
        end
    end

endmodule

//--- hw/register_file.sv
// 16 x 32 register file, two async read ports and one sync write port
module register_file (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [3:0]  raddr_a_i,
    input  logic [3:0]  raddr_b_i,
    input  logic [3:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic        we_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs_q [16];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != 4'd0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Entry 0 is hardwired to zero
    assign rdata_a_o = (raddr_a_i == 4'd0) ? 32'd0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 4'd0) ? 32'd0 : regs_q[raddr_b_i];

endmodule

//--- hw/mini_mcu_pkg.sv
// Shared types for the mini MCU: OBI request and response structs,
// instruction word views, opcodes and memory map constants
package mini_mcu_pkg;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } obi_resp_t;

    // Opcode sits in bits [31:28] of every instruction
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LUI  = 4'h6,
        OP_LW   = 4'h7,
        OP_SW   = 4'h8,
        OP_BEQ  = 4'h9,
        OP_JAL  = 4'hA,
        OP_MRET = 4'hB,
        OP_WFI  = 4'hC
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] unused;
    } reg_fmt_t;

    // SW and BEQ read the register named in rd
    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [19:0] imm;
    } imm_fmt_t;

    typedef union packed {
        reg_fmt_t reg_fmt;
        imm_fmt_t imm_fmt;
    } instr_u;

    localparam logic [31:0] BOOT_ADDR     = 32'h0000_0000;
    localparam logic [31:0] IRQ_VECTOR    = 32'h0000_0040;
    localparam int          RAM_WORDS     = 256;
    localparam logic [31:0] SOC_CTRL_ADDR = 32'h1000_0000;
    localparam int          NUM_IRQ       = 16;

endpackage
